// File: Makefile
# Verilator build and run for the serial transmitter

VERILATOR ?= verilator
TOP       ?= tb_tx_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(wildcard src/*.sv tb/*.sv)
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(EXE): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(EXE)
	-./$(EXE) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; exit 1; \
	elif ! grep -q "PASS: all tests" $(LOG); then \
		echo "Simulation ended without a result line, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
src/tx_pack.sv
src/tx_ctrl.sv
src/hr_16t4_mux.sv
src/qr_4t1_mux.sv
src/phase_delay.sv
src/output_buf_tx.sv
src/tx_top.sv
tb/tb_clkgen.sv
tb/tb_tx_top.sv

// File: src/hr_16t4_mux.sv
`timescale 1ns/100ps
`default_nettype none

module hr_16t4_mux (
    input  wire logic                       mdll_clk,
    input  wire logic                       rst,
    input  wire logic [tx_pack::WORD_W-1:0] din,        // Parallel word from source
    input  wire logic                       word_load,  // Capture strobe
    input  wire logic [tx_pack::CNT_W-1:0]  frame_cnt,
    output logic      [tx_pack::NIB_W-1:0]  nib         // To the 4:1 stage
);
    import tx_pack::*;

    logic [WORD_W-1:0] word_q;   // Reordered word
    logic [1:0]        grp;      // Quarter group, upper counter bits
    logic [1:0]        grp_off;  // Slot offset of the group

    assign grp = frame_cnt[CNT_W-1:CNT_W-2];

    // Half-rate tree picks groups in 0, 2, 1, 3 slot order
    assign grp_off = {grp[0], grp[1]};

    // Reorder on capture so the slot layout matches the mux tree
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            word_q <= '0;
        end else if (word_load) begin
            for (int s = 0; s < WORD_W; s++) begin
                word_q[s] <= din[REORDER[s]];
            end
        end
    end

    // Nibble bit q sits 4q slots below the group's top slot
    // Group 0 reads slots 15, 11, 7, 3 and so on down
    always_comb begin
        for (int q = 0; q < NIB_W; q++) begin
            nib[q] = word_q[WORD_W - 1 - NIB_W * q - int'(grp_off)];
        end
    end

endmodule

`default_nettype wire

// File: src/output_buf_tx.sv
`timescale 1ns/100ps
`default_nettype none

module output_buf_tx (
    input  wire logic mdll_clk,
    input  wire logic rst,
    input  wire logic ser_dly,  // Skewed serial data
    input  wire logic run,
    output logic      dout_p,   // True output
    output logic      dout_n    // Complement output
);
    import tx_pack::*;

    // Run history covers the mux register plus worst skew
    logic [2**NPI-1:0] run_sr;
    logic              drive;   // Drive differential this cycle

    assign drive = run || (|run_sr);

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            run_sr <= '0;
            dout_p <= 1'b0;
            dout_n <= 1'b0;
        end else begin
            run_sr <= {run_sr[2**NPI-2:0], run};
            dout_p <= drive ? ser_dly : 1'b0;   // Both low when idle
            dout_n <= drive ? ~ser_dly : 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/phase_delay.sv
`timescale 1ns/100ps
`default_nettype none

module phase_delay (
    input  wire logic                    mdll_clk,
    input  wire logic                    rst,
    input  wire logic                    ser_bit,  // Undelayed stream
    input  wire logic [tx_pack::NPI-1:0] skew,     // Delay in whole bits
    output logic                         ser_dly   // Skewed stream
);
    import tx_pack::*;

    // Three taps for skew 1 to 3
    logic [2**NPI-2:0] dly;

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            dly <= '0;
        end else begin
            dly <= {dly[2**NPI-3:0], ser_bit};  // Oldest bit at the top
        end
    end

    // Tap mux, skew 0 bypasses the line entirely
    always_comb begin
        case (skew)
            2'd0:    ser_dly = ser_bit;
            2'd1:    ser_dly = dly[0];
            2'd2:    ser_dly = dly[1];
            default: ser_dly = dly[2];
        endcase
    end

endmodule

`default_nettype wire

// File: src/qr_4t1_mux.sv
`timescale 1ns/100ps
`default_nettype none

module qr_4t1_mux (
    input  wire logic                      mdll_clk,
    input  wire logic                      rst,
    input  wire logic [tx_pack::NIB_W-1:0] nib,        // Current quarter group
    input  wire logic [tx_pack::CNT_W-1:0] frame_cnt,
    input  wire logic                      run,
    output logic                           ser_bit     // Bit-rate stream
);

    logic [1:0] phase;    // Quarter phase within the group
    logic       bit_sel;

    assign phase = frame_cnt[1:0];

    // One bit per quarter phase
    always_comb begin
        case (phase)
            2'd0:    bit_sel = nib[0];  // Q
            2'd1:    bit_sel = nib[1];  // I
            2'd2:    bit_sel = nib[2];  // QB
            default: bit_sel = nib[3];  // IB
        endcase
    end

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            ser_bit <= 1'b0;
        end else begin
            ser_bit <= run ? bit_sel : 1'b0;  // Park low when idle
        end
    end

    // Loaded word must be fully known once streaming
    a_ser_known: assert property (@(posedge mdll_clk) disable iff (rst)
        run |=> !$isunknown(ser_bit));

endmodule

`default_nettype wire

// File: src/tx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tx_ctrl (
    input  wire logic                      mdll_clk,   // Bit-rate clock
    input  wire logic                      rst,
    input  wire logic                      tx_en,      // Transmit enable level
    input  wire logic [tx_pack::NPI-1:0]   ctl_pi,     // Requested skew
    input  wire logic                      ctl_valid,  // Strobe for ctl_pi
    output logic      [tx_pack::CNT_W-1:0] frame_cnt,  // Bit period within frame
    output logic                           word_load,  // Word capture strobe
    output logic                           run,        // Streaming level
    output logic      [tx_pack::NPI-1:0]   skew        // Applied skew
);
    import tx_pack::*;

    tx_state_t      state;
    tx_state_t      state_nxt;
    logic           frame_end;
    logic [NPI-1:0] skew_pend;  // Waits here for the next word boundary

    assign frame_end = (frame_cnt == CNT_W'(FRAME_LEN - 1));

    // No load on the boundary where tx_en low takes us back to idle
    assign word_load = frame_end && tx_en && (state != ST_IDLE);
    assign run       = (state == ST_RUN);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (tx_en) begin
                    state_nxt = ST_ALIGN;
                end
            end
            ST_ALIGN: begin
                if (frame_end) begin
                    state_nxt = tx_en ? ST_RUN : ST_IDLE;  // First load starts the run
                end
            end
            ST_RUN: begin
                if (frame_end && !tx_en) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            frame_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Restart the frame on leaving idle, else free-run and wrap
            if (state == ST_IDLE && state_nxt != ST_IDLE) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // Skew takes effect only on a word boundary
    always_ff @(posedge mdll_clk) begin
        if (rst) begin
            skew_pend <= '0;
            skew      <= '0;
        end else begin
            if (ctl_valid) skew_pend <= ctl_pi;
            if (word_load) skew      <= skew_pend;
        end
    end

    // A load always follows a full frame out of idle
    a_load_after_align: assert property (@(posedge mdll_clk) disable iff (rst)
        word_load |-> $past(state, FRAME_LEN - 1) != ST_IDLE);

    // Fixed word period while enabled
    a_load_period: assert property (@(posedge mdll_clk) disable iff (rst)
        word_load |=> (!word_load)[*(FRAME_LEN - 1)] ##1 (word_load || !tx_en));

endmodule

`default_nettype wire

// File: src/tx_pack.sv
package tx_pack;

    // Parallel word and quarter-rate nibble widths
    localparam int WORD_W = 16;
    localparam int NIB_W  = 4;

    // Skew control width, whole-bit delay of 0 to 3
    localparam int NPI = 2;

    // Bit periods per word
    localparam int FRAME_LEN = 16;
    localparam int CNT_W     = $clog2(FRAME_LEN);  // Frame counter width

    // Enable FSM states
    typedef enum logic [1:0] {
        ST_IDLE,   // Outputs parked at 0
        ST_ALIGN,  // Counter restarted, waiting for the first word
        ST_RUN     // Streaming
    } tx_state_t;

    // Slot to din bit map for the reordered word
    // Slot 0 holds din[15], slot 4 holds din[14] and so on
    // The serializer emits slots 15, 11, 7, 3, 13, 9, 5, 1, 14, 10, 6, 2, 12, 8, 4, 0
    // which comes out as din[0] first and din[15] last
    localparam int REORDER [WORD_W] = '{
        15, 7, 11, 3,   // Slots 0 to 3
        14, 6, 10, 2,   // Slots 4 to 7
        13, 5, 9,  1,   // Slots 8 to 11
        12, 4, 8,  0    // Slots 12 to 15
    };

endpackage

// File: src/tx_top.sv
`timescale 1ns/100ps
`default_nettype none

module tx_top (
    input  wire logic                       mdll_clk,   // Bit-rate clock
    input  wire logic                       rst,        // Global reset
    input  wire logic [tx_pack::WORD_W-1:0] din,        // Word, sampled on word_req
    input  wire logic                       tx_en,
    input  wire logic [tx_pack::NPI-1:0]    ctl_pi,     // Skew request
    input  wire logic                       ctl_valid,
    output wire logic                       word_req,   // Source presents din here
    output wire logic                       dout_p,
    output wire logic                       dout_n
);
    import tx_pack::*;

    wire logic [CNT_W-1:0] frame_cnt;
    wire logic             run;
    wire logic [NPI-1:0]   skew;
    wire logic [NIB_W-1:0] nib;      // 16:4 stage to 4:1 stage
    wire logic             ser_bit;  // Serializer out
    wire logic             ser_dly;  // After skew

    // Frame timing, enable FSM and skew update
    tx_ctrl u_ctrl (
        .mdll_clk  (mdll_clk),
        .rst       (rst),
        .tx_en     (tx_en),
        .ctl_pi    (ctl_pi),
        .ctl_valid (ctl_valid),
        .frame_cnt (frame_cnt),
        .word_load (word_req),
        .run       (run),
        .skew      (skew)
    );

    // Half-rate 16 to 4 stage
    hr_16t4_mux u_hr_mux (
        .mdll_clk  (mdll_clk),
        .rst       (rst),
        .din       (din),
        .word_load (word_req),
        .frame_cnt (frame_cnt),
        .nib       (nib)
    );

    // Quarter-rate 4 to 1 stage
    qr_4t1_mux u_qr_mux (
        .mdll_clk  (mdll_clk),
        .rst       (rst),
        .nib       (nib),
        .frame_cnt (frame_cnt),
        .run       (run),
        .ser_bit   (ser_bit)
    );

    phase_delay u_pdly (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .ser_bit  (ser_bit),
        .skew     (skew),
        .ser_dly  (ser_dly)
    );

    output_buf_tx u_obuf (
        .mdll_clk (mdll_clk),
        .rst      (rst),
        .ser_dly  (ser_dly),
        .run      (run),
        .dout_p   (dout_p),
        .dout_n   (dout_n)
    );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
    output logic mdll_clk,  // Bit-rate clock, 100 ns period
    output logic rst        // Synchronous reset, active high
);

    initial begin
        mdll_clk = 1'b0;
        forever #50 mdll_clk = ~mdll_clk;  // Half period
    end

    // Reset held over 8 rising edges, dropped on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge mdll_clk);
        @(negedge mdll_clk);
        rst = 1'b0;
    end

endmodule

// File: tb/tb_tx_top.sv
`timescale 1ns/100ps

module tb_tx_top;
    import tx_pack::*;

    logic              mdll_clk;
    logic              rst;
    logic [WORD_W-1:0] din;
    logic              tx_en;
    logic [NPI-1:0]    ctl_pi;
    logic              ctl_valid;
    wire               word_req;
    wire               dout_p;
    wire               dout_n;

    integer         seed;
    int             err_data     = 0;     // Wrong output bits or levels
    int             err_proto    = 0;     // Request timing and coverage
    int             err_wait     = 0;     // Timeouts
    int             cyc          = -1;    // Rising edges since reset release
    int             first_load   = -1;    // Edge of the very first load
    int             last_req     = 0;
    bit             spacing_on   = 1'b0;  // Request spacing check armed
    bit             expect_quiet = 1'b1;  // Outputs and requests must stay low
    bit             quiet_q      = 1'b0;  // Quiet flag seen at the last edge
    int             words        = 0;     // Words loaded so far
    int             bits_checked = 0;
    int             skew_words [2**NPI];  // Words sent per skew value
    logic [NPI-1:0] m_pend       = '0;    // Model pending skew
    logic [NPI-1:0] m_skew       = '0;    // Model applied skew
    bit             stream [int];         // Serial bit per bit slot
    logic [NPI-1:0] skew_at [int];        // Applied skew after each edge

    tb_clkgen u_clkgen (
        .mdll_clk (mdll_clk),
        .rst      (rst)
    );

    tx_top u_tx_top (
        .mdll_clk  (mdll_clk),
        .rst       (rst),
        .din       (din),
        .tx_en     (tx_en),
        .ctl_pi    (ctl_pi),
        .ctl_valid (ctl_valid),
        .word_req  (word_req),
        .dout_p    (dout_p),
        .dout_n    (dout_n)
    );

    // Reference model, fed at the edge where inputs are stable
    always @(posedge mdll_clk) begin
        if (!rst) begin
            cyc     = cyc + 1;
            quiet_q = expect_quiet;
            if (expect_quiet) begin
                assert (!word_req) else begin
                    err_proto++;
                    $display("Error: %0t word_req high while disabled", $time);
                end
            end
            if (word_req) begin
                // Bit slot k+i carries din[i], LSB first
                for (int i = 0; i < WORD_W; i++) begin
                    stream[cyc + i] = din[i];
                end
                m_skew = m_pend;  // Pending skew lands on the word boundary
                skew_words[m_skew]++;
                if (first_load < 0) first_load = cyc;
                if (spacing_on) begin
                    assert (cyc - last_req == FRAME_LEN) else begin
                        err_proto++;
                        $display("Error: %0t word_req %0d cycles after the previous, expected %0d",
                                 $time, cyc - last_req, FRAME_LEN);
                    end
                end
                last_req   = cyc;
                spacing_on = 1'b1;
                words++;
            end else if (spacing_on) begin
                assert (cyc - last_req < FRAME_LEN) else begin
                    err_proto++;
                    spacing_on = 1'b0;
                    $display("Error: %0t word_req missing at the end of a frame", $time);
                end
            end
            if (!tx_en) spacing_on = 1'b0;  // Next spacing not defined
            if (ctl_valid) m_pend = ctl_pi;
            skew_at[cyc] = m_skew;
        end
    end

    // Output checks half a cycle after each edge
    always @(negedge mdll_clk) begin : check_out
        int slot;
        if (cyc >= 0) begin
            if (first_load < 0 || cyc <= first_load || quiet_q) begin
                assert (dout_p === 1'b0 && dout_n === 1'b0) else begin
                    err_data++;
                    $display("Error: %0t dout_p %b dout_n %b, expected idle 0 0",
                             $time, dout_p, dout_n);
                end
            end else if (skew_at.exists(cyc - 1)) begin
                // Bit emitted now left the serializer 2 + skew edges back
                slot = cyc - 2 - int'(skew_at[cyc - 1]);
                if (stream.exists(slot)) begin
                    bits_checked++;
                    assert (dout_p === stream[slot]) else begin
                        err_data++;
                        $display("Error: %0t dout_p %b, expected %b (slot %0d, skew %0d)",
                                 $time, dout_p, stream[slot], slot, skew_at[cyc - 1]);
                    end
                    assert (dout_n === ~stream[slot]) else begin
                        err_data++;
                        $display("Error: %0t dout_n %b, expected %b (complement of slot %0d)",
                                 $time, dout_n, ~stream[slot], slot);
                    end
                end
            end
        end
    end

    task automatic finish_run();
        $display("Errors: %0d data, %0d protocol, %0d timeout (%0d bits checked)",
                 err_data, err_proto, err_wait, bits_checked);
        if (err_data + err_proto + err_wait == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // One falling edge, fresh random word on din every cycle
    task automatic next_cycle();
        @(negedge mdll_clk);
        din       = WORD_W'($random(seed));
        ctl_valid = 1'b0;  // Strobes last one cycle
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < 50) begin
            @(posedge mdll_clk);
            n++;
        end
        if (rst !== 1'b0) begin
            err_wait++;
            $display("Reset was never released");
            finish_run();
        end else begin
            @(negedge mdll_clk);
        end
    endtask

    task automatic wait_words(input int n);
        int target;
        int limit;
        target = words + n;
        limit  = (n + 2) * FRAME_LEN;  // Align frame plus margin
        while (words < target && limit > 0) begin
            next_cycle();
            limit--;
        end
        if (words < target) begin
            err_wait++;
            $display("word_req never pulsed, %0d of %0d words seen", words, target);
            finish_run();
        end
    endtask

    // Random skew writes at a random point inside each frame
    task automatic stream_with_skew_changes(input int n);
        int d;
        repeat (n) begin
            wait_words(1);
            d = 1 + int'($unsigned($random(seed)) % 12);
            repeat (d) next_cycle();
            if (($random(seed) & 3) != 0) begin
                ctl_pi    = NPI'($random(seed));
                ctl_valid = 1'b1;
            end
        end
    endtask

    initial begin
        int held;
        seed       = 32'h63a9_d340;
        din        = '0;
        tx_en      = 1'b0;
        ctl_pi     = '0;
        ctl_valid  = 1'b0;
        skew_words = '{default: 0};
        wait_reset();

        // Idle with tx_en low
        repeat (20) next_cycle();

        // Back to back words at skew 0
        tx_en        = 1'b1;
        expect_quiet = 1'b0;
        wait_words(40);

        stream_with_skew_changes(60);

        // Drop tx_en mid frame, the current word still goes out
        wait_words(1);
        repeat (5) next_cycle();
        tx_en = 1'b0;
        held  = words;
        repeat (FRAME_LEN + 8) next_cycle();
        expect_quiet = 1'b1;
        repeat (2 * FRAME_LEN) next_cycle();
        assert (words == held) else begin
            err_proto++;
            $display("word_req kept pulsing after tx_en went low");
        end

        // Enable again
        expect_quiet = 1'b0;
        tx_en        = 1'b1;
        stream_with_skew_changes(20);
        repeat (FRAME_LEN + 8) next_cycle();  // Drain the last word

        for (int s = 0; s < 2**NPI; s++) begin
            assert (skew_words[s] > 0) else begin
                err_proto++;
                $display("Skew %0d was never applied to a word", s);
            end
        end
        assert (bits_checked >= 1500) else begin
            err_proto++;
            $display("Only %0d output bits were checked", bits_checked);
        end
        finish_run();
    end

endmodule
